// ==== hw/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // core dimensions
    localparam int XLEN      = 32;
    localparam int NUM_REGS  = 32;
    localparam int ROB_DEPTH = 8;
    localparam int RS_DEPTH  = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // tag 0 means the value sits in the register file
    typedef logic [3:0]      rob_tag_t;

    typedef logic [15:0]     imm_t;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        // signed compare
        op_slt = 3'd5,
        op_sll = 3'd6,
        op_srl = 3'd7
    } alu_op_t;

endpackage

`default_nettype wire

// ==== hw/rename_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_regfile import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     rename_en,
    input  reg_idx_t rename_rd,
    input  rob_tag_t rename_tag,
    input  logic     commit_en,
    input  reg_idx_t commit_rd,
    input  rob_tag_t commit_tag,
    input  word_t    commit_data,
    output word_t    rs_val,
    output word_t    rt_val,
    output rob_tag_t rs_tag,
    output rob_tag_t rt_tag
);

    word_t    regs [NUM_REGS];
    rob_tag_t tags [NUM_REGS];

    // r0 is hardwired to zero and never renamed
    assign rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_val = (rt_idx == '0) ? '0 : regs[rt_idx];
    assign rs_tag = (rs_idx == '0) ? '0 : tags[rs_idx];
    assign rt_tag = (rt_idx == '0) ? '0 : tags[rt_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit_en && commit_rd != '0) begin
                regs[commit_rd] <= commit_data;
                // only the latest producer may release the register
                if (tags[commit_rd] == commit_tag &&
                    !(rename_en && rename_rd == commit_rd)) begin
                    tags[commit_rd] <= '0;
                end
            end
            if (rename_en && rename_rd != '0) begin
                tags[rename_rd] <= rename_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     alloc_en,
    input  reg_idx_t alloc_rd,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_data,
    input  rob_tag_t rd_tag_a,
    input  rob_tag_t rd_tag_b,
    output rob_tag_t alloc_tag,
    output logic     rob_full,
    output word_t    rd_val_a,
    output word_t    rd_val_b,
    output logic     rd_ready_a,
    output logic     rd_ready_b,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output rob_tag_t commit_tag,
    output word_t    commit_data
);

    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_ptr_t;

    rob_ptr_t                         head;
    rob_ptr_t                         tail;
    logic [$clog2(ROB_DEPTH+1)-1:0]   count;

    reg_idx_t             ent_rd   [ROB_DEPTH];
    word_t                ent_data [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_ready;

    rob_ptr_t a_ptr;
    rob_ptr_t b_ptr;

    // entry n carries tag n+1
    function automatic rob_ptr_t tag_to_ptr(input rob_tag_t tag);
        rob_tag_t slot;
        slot = tag - rob_tag_t'(1);
        return slot[$bits(rob_ptr_t)-1:0];
    endfunction

    function automatic rob_tag_t ptr_to_tag(input rob_ptr_t ptr);
        return rob_tag_t'(ptr) + rob_tag_t'(1);
    endfunction

    assign alloc_tag = ptr_to_tag(tail);
    assign rob_full  = (count == ROB_DEPTH);

    // dispatch lookups of finished but uncommitted results
    assign a_ptr      = tag_to_ptr(rd_tag_a);
    assign b_ptr      = tag_to_ptr(rd_tag_b);
    assign rd_val_a   = ent_data[a_ptr];
    assign rd_val_b   = ent_data[b_ptr];
    assign rd_ready_a = ent_ready[a_ptr];
    assign rd_ready_b = ent_ready[b_ptr];

    // head retires as soon as its result is in
    assign commit_valid = (count != '0) && ent_ready[head];
    assign commit_rd    = ent_rd[head];
    assign commit_tag   = ptr_to_tag(head);
    assign commit_data  = ent_data[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_ready <= '0;
        end else begin
            if (alloc_en) begin
                ent_rd[tail]    <= alloc_rd;
                ent_ready[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (cdb_valid) begin
                ent_data[tag_to_ptr(cdb_tag)]  <= cdb_data;
                ent_ready[tag_to_ptr(cdb_tag)] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            if (alloc_en && !commit_valid) begin
                count <= count + 1'b1;
            end else if (!alloc_en && commit_valid) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     disp_en,
    input  alu_op_t  disp_op,
    input  rob_tag_t disp_tag,
    input  rob_tag_t disp_a_tag,
    input  word_t    disp_a_val,
    input  rob_tag_t disp_b_tag,
    input  word_t    disp_b_val,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_data,
    output logic     rs_full,
    output logic     exec_valid,
    output alu_op_t  exec_op,
    output rob_tag_t exec_tag,
    output word_t    exec_a,
    output word_t    exec_b
);

    typedef logic [$clog2(RS_DEPTH)-1:0] slot_idx_t;

    logic [RS_DEPTH-1:0] slot_valid;
    alu_op_t             slot_op    [RS_DEPTH];
    rob_tag_t            slot_tag   [RS_DEPTH];
    rob_tag_t            slot_a_tag [RS_DEPTH];
    rob_tag_t            slot_b_tag [RS_DEPTH];
    word_t               slot_a_val [RS_DEPTH];
    word_t               slot_b_val [RS_DEPTH];
    // ahead[i] marks the slots dispatched before slot i
    logic [RS_DEPTH-1:0] ahead      [RS_DEPTH];

    logic [RS_DEPTH-1:0] slot_ready;
    slot_idx_t           free_idx;
    slot_idx_t           issue_idx;

    function automatic logic bus_hit(input rob_tag_t tag);
        return cdb_valid && tag != '0 && tag == cdb_tag;
    endfunction

    assign rs_full = &slot_valid;

    // lowest free slot takes the next dispatch
    always_comb begin
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) free_idx = slot_idx_t'(i);
        end
    end

    // oldest slot with both operands in hand
    always_comb begin
        exec_valid = 1'b0;
        issue_idx  = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            slot_ready[i] = slot_valid[i] && slot_a_tag[i] == '0 && slot_b_tag[i] == '0;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (slot_ready[i] && !(|(slot_ready & ahead[i]))) begin
                exec_valid = 1'b1;
                issue_idx  = slot_idx_t'(i);
            end
        end
    end

    assign exec_op  = slot_op[issue_idx];
    assign exec_tag = slot_tag[issue_idx];
    assign exec_a   = slot_a_val[issue_idx];
    assign exec_b   = slot_b_val[issue_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
            for (int i = 0; i < RS_DEPTH; i++) ahead[i] <= '0;
        end else begin
            // wake waiting operands from the result bus
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (slot_valid[i] && bus_hit(slot_a_tag[i])) begin
                    slot_a_tag[i] <= '0;
                    slot_a_val[i] <= cdb_data;
                end
                if (slot_valid[i] && bus_hit(slot_b_tag[i])) begin
                    slot_b_tag[i] <= '0;
                    slot_b_val[i] <= cdb_data;
                end
            end
            if (exec_valid) slot_valid[issue_idx] <= 1'b0;
            if (disp_en) begin
                slot_valid[free_idx] <= 1'b1;
                slot_op[free_idx]    <= disp_op;
                slot_tag[free_idx]   <= disp_tag;
                // a result on the bus right now is caught at dispatch
                slot_a_tag[free_idx] <= bus_hit(disp_a_tag) ? '0 : disp_a_tag;
                slot_a_val[free_idx] <= bus_hit(disp_a_tag) ? cdb_data : disp_a_val;
                slot_b_tag[free_idx] <= bus_hit(disp_b_tag) ? '0 : disp_b_tag;
                slot_b_val[free_idx] <= bus_hit(disp_b_tag) ? cdb_data : disp_b_val;
                for (int i = 0; i < RS_DEPTH; i++) ahead[i][free_idx] <= 1'b0;
                ahead[free_idx] <= slot_valid;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_alu import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     exec_valid,
    input  alu_op_t  exec_op,
    input  rob_tag_t exec_tag,
    input  word_t    exec_a,
    input  word_t    exec_b,
    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output word_t    cdb_data
);

    word_t result;

    always_comb begin
        case (exec_op)
            op_add:  result = exec_a + exec_b;
            op_sub:  result = exec_a - exec_b;
            op_and:  result = exec_a & exec_b;
            op_or:   result = exec_a | exec_b;
            op_xor:  result = exec_a ^ exec_b;
            op_slt:  result = {{(XLEN-1){1'b0}}, $signed(exec_a) < $signed(exec_b)};
            // shift amount from the low five bits
            op_sll:  result = exec_a << exec_b[4:0];
            op_srl:  result = exec_a >> exec_b[4:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
            cdb_tag   <= '0;
        end else begin
            cdb_valid <= exec_valid;
            cdb_tag   <= exec_tag;
            cdb_data  <= result;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue_valid,
    input  alu_op_t  issue_op,
    input  reg_idx_t issue_rd,
    input  reg_idx_t issue_rs,
    input  reg_idx_t issue_rt,
    input  logic     issue_use_imm,
    input  imm_t     issue_imm,
    output logic     full,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output word_t    commit_data,
    output word_t    cycles_consumed
);

    word_t    rs_val, rt_val, rob_val_a, rob_val_b, imm_ext;
    rob_tag_t rs_tag, rt_tag, alloc_tag, commit_tag;
    logic     rob_full, station_full, rob_ready_a, rob_ready_b, disp;
    rob_tag_t op_a_tag, op_b_tag;
    word_t    op_a_val, op_b_val;
    // result bus, single producer
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    word_t    cdb_data;
    logic     exec_valid;
    alu_op_t  exec_op;
    rob_tag_t exec_tag;
    word_t    exec_a, exec_b;

    assign full    = rob_full | station_full;
    assign disp    = issue_valid & ~full;
    assign imm_ext = {{(XLEN - $bits(imm_t)){issue_imm[$bits(imm_t)-1]}}, issue_imm};

    // value from regfile, else a finished ROB entry, else wait on the tag
    assign op_a_tag = (rs_tag == '0 || rob_ready_a) ? '0 : rs_tag;
    assign op_a_val = (rs_tag == '0) ? rs_val : rob_val_a;
    assign op_b_tag = (issue_use_imm || rt_tag == '0 || rob_ready_b) ? '0 : rt_tag;
    assign op_b_val = issue_use_imm ? imm_ext : ((rt_tag == '0) ? rt_val : rob_val_b);

    always_ff @(posedge clk) begin
        if (rst) cycles_consumed <= '0;
        else cycles_consumed <= cycles_consumed + 1'b1;
    end

    rename_regfile u_regfile (
        .clk(clk), .rst(rst), .rs_idx(issue_rs), .rt_idx(issue_rt),
        .rename_en(disp), .rename_rd(issue_rd), .rename_tag(alloc_tag),
        .commit_en(commit_valid), .commit_rd(commit_rd), .commit_tag(commit_tag),
        .commit_data(commit_data), .rs_val(rs_val), .rt_val(rt_val),
        .rs_tag(rs_tag), .rt_tag(rt_tag)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst(rst), .alloc_en(disp), .alloc_rd(issue_rd),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .rd_tag_a(rs_tag), .rd_tag_b(rt_tag), .alloc_tag(alloc_tag), .rob_full(rob_full),
        .rd_val_a(rob_val_a), .rd_val_b(rob_val_b),
        .rd_ready_a(rob_ready_a), .rd_ready_b(rob_ready_b),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_tag(commit_tag), .commit_data(commit_data)
    );

    reservation_station u_rs (
        .clk(clk), .rst(rst), .disp_en(disp), .disp_op(issue_op), .disp_tag(alloc_tag),
        .disp_a_tag(op_a_tag), .disp_a_val(op_a_val),
        .disp_b_tag(op_b_tag), .disp_b_val(op_b_val),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .rs_full(station_full), .exec_valid(exec_valid), .exec_op(exec_op),
        .exec_tag(exec_tag), .exec_a(exec_a), .exec_b(exec_b)
    );

    int_alu u_alu (
        .clk(clk), .rst(rst), .exec_valid(exec_valid), .exec_op(exec_op),
        .exec_tag(exec_tag), .exec_a(exec_a), .exec_b(exec_b),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
    );

endmodule

`default_nettype wire

// ==== tests/ooo_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_properties import ooo_pkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic disp,
    input wire logic commit_valid,
    input wire logic full
);

    // instructions accepted but not yet retired
    int outstanding;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(disp) - int'(commit_valid);
        end
    end

    no_commit_in_reset: assert property (@(posedge clk) rst |-> commit_valid !== 1'b1)
        else $error("commit_valid high while rst is asserted");

    no_commit_when_empty: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> outstanding != 0)
        else $error("commit with no instruction outstanding");

    full_at_capacity: assert property (@(posedge clk) disable iff (rst)
        outstanding == ROB_DEPTH |-> full)
        else $error("full low with every ROB entry in use");

endmodule

bind ooo_core ooo_core_properties u_properties (
    .clk(clk),
    .rst(rst),
    .disp(disp),
    .commit_valid(commit_valid),
    .full(full)
);

`default_nettype wire

// ==== tests/ooo_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int STIM_ATTEMPTS   = 600;
    localparam int DRAIN_MARGIN    = 200;
    localparam int WATCHDOG_CYCLES = STIM_ATTEMPTS * 20 + DRAIN_MARGIN;

    logic     clk = 1'b0;
    logic     rst;
    logic     issue_valid;
    alu_op_t  issue_op;
    reg_idx_t issue_rd;
    reg_idx_t issue_rs;
    reg_idx_t issue_rt;
    logic     issue_use_imm;
    imm_t     issue_imm;
    logic     full;
    logic     commit_valid;
    reg_idx_t commit_rd;
    word_t    commit_data;
    word_t    cycles_consumed;

    logic [31:0] lcg_state = 32'hb9522477;
    int          error_count  = 0;
    int          accept_count = 0;
    int          commit_count = 0;
    word_t       ref_cycles   = '0;
    logic        seen_run     = 1'b0;

    // sequential model state and expected commits in program order
    word_t    model_regs [NUM_REGS];
    reg_idx_t exp_rd_q   [$];
    word_t    exp_data_q [$];

    ooo_core UUT (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_rd(issue_rd), .issue_rs(issue_rs), .issue_rt(issue_rt),
        .issue_use_imm(issue_use_imm), .issue_imm(issue_imm), .full(full),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data),
        .cycles_consumed(cycles_consumed)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // mostly r0..r3 so that instructions depend on each other
    function automatic reg_idx_t pick_reg();
        logic [31:0] r;
        r = next_random();
        if (r[31:30] != 2'b00) return reg_idx_t'(r[21:20]);
        return r[24:20];
    endfunction

    function automatic word_t model_result(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            op_sll:  return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("Fail: %s = %h, expected %h", name, got, exp);
        error_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error: %s", msg);
        error_count++;
    endtask

    task automatic print_summary();
        $display("Summary: %0d errors, %0d accepted, %0d committed",
                 error_count, accept_count, commit_count);
    endtask

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        print_summary();
        $display("Test failures found");
        $finish;
    end

    // outputs are stable at the falling edge and show what the next rising edge does
    always @(negedge clk) begin
        word_t a;
        word_t b;
        word_t res;
        if (rst) begin
            if (commit_valid !== 1'b0) report_mismatch("commit_valid", commit_valid, 0);
            if (full !== 1'b0) report_mismatch("full", full, 0);
        end else begin
            if (!seen_run) begin
                if (commit_valid !== 1'b0) report_mismatch("commit_valid", commit_valid, 0);
                if (full !== 1'b0) report_mismatch("full", full, 0);
                seen_run = 1'b1;
            end
            if (cycles_consumed !== ref_cycles) begin
                report_mismatch("cycles_consumed", cycles_consumed, ref_cycles);
            end
            ref_cycles++;
            if (commit_valid === 1'b1) begin
                commit_count++;
                if (exp_rd_q.size() == 0) begin
                    report_problem("commit seen with no accepted instruction outstanding");
                end else begin
                    if (commit_rd !== exp_rd_q[0]) begin
                        report_mismatch("commit_rd", commit_rd, exp_rd_q[0]);
                    end
                    if (commit_data !== exp_data_q[0]) begin
                        report_mismatch("commit_data", commit_data, exp_data_q[0]);
                    end
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                end
            end
            if (issue_valid && full === 1'b0) begin
                a   = model_regs[issue_rs];
                b   = issue_use_imm ? {{16{issue_imm[15]}}, issue_imm} : model_regs[issue_rt];
                res = model_result(issue_op, a, b);
                if (issue_rd != '0) model_regs[issue_rd] = res;
                exp_rd_q.push_back(issue_rd);
                exp_data_q.push_back(res);
                accept_count++;
            end
            if (exp_rd_q.size() > ROB_DEPTH) begin
                report_problem("more than eight instructions outstanding");
            end
        end
    end

    initial begin
        int          attempts;
        int          burst_left;
        int          gap_left;
        logic [31:0] r;
        attempts      = 0;
        burst_left    = 8;
        gap_left      = 0;
        rst           = 1'b1;
        issue_valid   = 1'b0;
        issue_op      = op_add;
        issue_rd      = '0;
        issue_rs      = '0;
        issue_rt      = '0;
        issue_use_imm = 1'b0;
        issue_imm     = '0;
        for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // bursts of random instructions separated by idle gaps
        while (attempts < STIM_ATTEMPTS) begin
            @(posedge clk);
            if (gap_left > 0) begin
                issue_valid <= 1'b0;
                gap_left--;
            end else begin
                r = next_random();
                issue_valid   <= 1'b1;
                issue_op      <= alu_op_t'(r[31:29]);
                issue_use_imm <= r[28];
                issue_imm     <= imm_t'(next_random() >> 16);
                issue_rd      <= pick_reg();
                issue_rs      <= pick_reg();
                issue_rt      <= pick_reg();
                attempts++;
                burst_left--;
                if (burst_left == 0) begin
                    r = next_random();
                    burst_left = 1 + int'(r[31:28]);
                    gap_left   = int'(r[27:25]);
                end
            end
        end
        @(posedge clk);
        issue_valid <= 1'b0;

        // drain
        while (exp_rd_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (commit_count != accept_count) begin
            report_problem("commit count differs from accepted instruction count");
        end
        if (full !== 1'b0) report_mismatch("full", full, 0);

        print_summary();
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/ooo_pkg.sv
hw/rename_regfile.sv
hw/reorder_buffer.sv
hw/reservation_station.sv
hw/int_alu.sv
hw/ooo_core.sv
tests/ooo_core_properties.sv
tests/ooo_core_tb.sv
